/* Makefile */
TOP := cfg_chain_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f cfg_chain.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* cfg_chain.f */
+incdir+include
design/cfg_chain_pkg.sv
design/cfg_tx_if.sv
design/cfg_host_fsm.sv
design/cfg_bit_counter.sv
design/cfg_serializer.sv
design/cfg_node.sv
design/cfg_chain_top.sv
test/cfg_chain_properties.sv
test/cfg_chain_tb.sv

/* design/cfg_bit_counter.sv */
`timescale 1ns/10ps
`include "cfg_chain_defines.svh"

module cfg_bit_counter (
  input  logic  clk,
  input  logic  reset,
  cfg_tx_if.cnt tx
);

  localparam int unsigned cnt_bits = $clog2(`CFG_PKT_BITS);
  localparam logic [cnt_bits-1:0] cnt_last = cnt_bits'(`CFG_PKT_BITS - 1);

  logic                active_r; // a frame is on the line
  logic [cnt_bits-1:0] cnt_r;    // index of the bit currently on the line

  // start comes in the handshake cycle, so count 0 matches bit 0 on the line
  always_ff @(posedge clk) begin
    if (reset) begin
      active_r <= 1'b0;
      cnt_r    <= '0;
    end else if (tx.start) begin
      active_r <= 1'b1;
      cnt_r    <= '0;
    end else if (tx.last) begin
      active_r <= 1'b0; // frame done, hold here until the next start
      cnt_r    <= '0;
    end else if (active_r) begin
      cnt_r <= cnt_r + 1'b1;
    end
  end

  // high for exactly the cycle that carries bit 35
  assign tx.last = active_r && (cnt_r == cnt_last);

endmodule

/* design/cfg_chain_pkg.sv */
`include "cfg_chain_defines.svh"

package cfg_chain_pkg;

  // field order follows the line order from the top down
  // valid sits at the bottom and therefore goes out first
  typedef struct packed {
    logic [`CFG_RX_BITS-1:0]    rx;    // payload with the framing zeros still inside
    logic [`CFG_ID_BITS-1:0]    id;    // target node
    logic [`CFG_LEN_BITS-1:0]   len;   // frame length, used by the node as a hold-off count
    logic [`CFG_VALID_BITS-1:0] valid; // 2'b10 marks a real packet
  } cfg_packet_s;

  // one shift register word seen two ways
  // the node decodes packet fields through pkt and spots the reset run through raw
  typedef union packed {
    cfg_packet_s              pkt;
    logic [`CFG_PKT_BITS-1:0] raw;
  } cfg_frame_u;

  // what the host asked the sequencer to put on the line
  typedef enum logic {
    CFG_REQ_PACKET,
    CFG_REQ_RESET
  } cfg_req_e;

endpackage

/* design/cfg_chain_top.sv */
`timescale 1ns/10ps
`include "cfg_chain_defines.svh"

module cfg_chain_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          axi_awvalid_i,
  output logic                          axi_awready_o,
  input  logic [`CFG_AXI_ADDR_BITS-1:0] axi_awaddr_i,
  input  logic                          axi_wvalid_i,
  output logic                          axi_wready_o,
  input  logic [`CFG_AXI_DATA_BITS-1:0] axi_wdata_i,
  output logic                          axi_bvalid_o,
  input  logic                          axi_bready_i,
  output logic [1:0]                    axi_bresp_o,
  input  logic                          axi_arvalid_i,
  output logic                          axi_arready_o,
  input  logic [`CFG_AXI_ADDR_BITS-1:0] axi_araddr_i,
  output logic                          axi_rvalid_o,
  input  logic                          axi_rready_i,
  output logic [`CFG_AXI_DATA_BITS-1:0] axi_rdata_o,
  output logic [1:0]                    axi_rresp_o,
  output logic [`CFG_DATA_BITS-1:0]     node0_data_o,
  output logic [`CFG_DATA_BITS-1:0]     node1_data_o,
  output logic                          node0_new_o,
  output logic                          node1_new_o,
  output logic                          cfg_line_o
);

  cfg_tx_if tx ();

  cfg_host_fsm i_cfg_host_fsm (
    .clk           (clk),
    .reset         (reset),
    .axi_awvalid_i (axi_awvalid_i),
    .axi_awready_o (axi_awready_o),
    .axi_awaddr_i  (axi_awaddr_i),
    .axi_wvalid_i  (axi_wvalid_i),
    .axi_wready_o  (axi_wready_o),
    .axi_wdata_i   (axi_wdata_i),
    .axi_bvalid_o  (axi_bvalid_o),
    .axi_bready_i  (axi_bready_i),
    .axi_bresp_o   (axi_bresp_o),
    .axi_arvalid_i (axi_arvalid_i),
    .axi_arready_o (axi_arready_o),
    .axi_araddr_i  (axi_araddr_i),
    .axi_rvalid_o  (axi_rvalid_o),
    .axi_rready_i  (axi_rready_i),
    .axi_rdata_o   (axi_rdata_o),
    .axi_rresp_o   (axi_rresp_o),
    .tx            (tx)
  );

  cfg_bit_counter i_cfg_bit_counter (.clk(clk), .reset(reset), .tx(tx));

  cfg_serializer i_cfg_serializer (.clk(clk), .reset(reset), .tx(tx));

  // both nodes listen to the same broadcast line
  cfg_node #(.NODE_ID(`CFG_NODE0_ID), .DEFAULT_DATA(`CFG_NODE0_DEFAULT)) i_cfg_node0 (
    .clk    (clk),
    .reset  (reset),
    .line_i (tx.line),
    .data_o (node0_data_o),
    .new_o  (node0_new_o)
  );

  cfg_node #(.NODE_ID(`CFG_NODE1_ID), .DEFAULT_DATA(`CFG_NODE1_DEFAULT)) i_cfg_node1 (
    .clk    (clk),
    .reset  (reset),
    .line_i (tx.line),
    .data_o (node1_data_o),
    .new_o  (node1_new_o)
  );

  assign cfg_line_o = tx.line; // brought out so the line can be watched from outside

endmodule

/* design/cfg_host_fsm.sv */
`timescale 1ns/10ps
`include "cfg_chain_defines.svh"

module cfg_host_fsm (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          axi_awvalid_i,
  output logic                          axi_awready_o,
  input  logic [`CFG_AXI_ADDR_BITS-1:0] axi_awaddr_i,
  input  logic                          axi_wvalid_i,
  output logic                          axi_wready_o,
  input  logic [`CFG_AXI_DATA_BITS-1:0] axi_wdata_i,
  output logic                          axi_bvalid_o,
  input  logic                          axi_bready_i,
  output logic [1:0]                    axi_bresp_o,
  input  logic                          axi_arvalid_i,
  output logic                          axi_arready_o,
  input  logic [`CFG_AXI_ADDR_BITS-1:0] axi_araddr_i,
  output logic                          axi_rvalid_o,
  input  logic                          axi_rready_i,
  output logic [`CFG_AXI_DATA_BITS-1:0] axi_rdata_o,
  output logic [1:0]                    axi_rresp_o,
  cfg_tx_if.host                        tx
);

  typedef enum logic [1:0] {IDLE, SEND, RESP} state_e;

  state_e                         state_r;
  logic                           wr_ready_r; // shared by aw and w, they always handshake together
  logic                           bvalid_r;
  logic                           arready_r;
  logic                           rvalid_r;
  logic [`CFG_AXI_DATA_BITS-1:0]  rdata_r;
  logic                           wr_hs;
  logic                           ar_hs;
  logic                           is_packet;
  logic                           is_reset;
  logic                           busy;

  assign wr_hs     = axi_awvalid_i & axi_wvalid_i & wr_ready_r; // both channels in one cycle
  assign ar_hs     = axi_arvalid_i & arready_r;
  assign is_packet = axi_awaddr_i == `CFG_ADDR_PACKET;
  assign is_reset  = axi_awaddr_i == `CFG_ADDR_RESET;
  assign busy      = state_r == SEND; // frame bits are on the line

  // launch straight from the handshake so bit 0 lands on the line in the next cycle
  assign tx.start = wr_hs & (is_packet | is_reset);
  assign tx.kind  = is_reset ? cfg_chain_pkg::CFG_REQ_RESET : cfg_chain_pkg::CFG_REQ_PACKET;
  assign tx.id    = axi_wdata_i[16 +: `CFG_ID_BITS];
  assign tx.data  = axi_wdata_i[`CFG_DATA_BITS-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      state_r    <= IDLE;
      wr_ready_r <= 1'b0;
      bvalid_r   <= 1'b0;
    end else begin
      if (wr_hs) bvalid_r <= 1'b1;                   // response goes up one cycle after the write
      else if (axi_bready_i) bvalid_r <= 1'b0;
      case (state_r)
        IDLE: begin
          if (wr_hs) begin
            wr_ready_r <= 1'b0;
            state_r    <= tx.start ? SEND : RESP;    // unmapped writes only get their response
          end else if (!bvalid_r) begin
            wr_ready_r <= 1'b1;
          end
        end
        SEND: if (tx.last) state_r <= RESP;          // final bit is on the line this cycle
        RESP: if (!bvalid_r || axi_bready_i) state_r <= IDLE;
        default: state_r <= IDLE;
      endcase
    end
  end

  // read side runs on its own so status polls work while a frame is going out
  always_ff @(posedge clk) begin
    if (reset) begin
      arready_r <= 1'b0;
      rvalid_r  <= 1'b0;
    end else if (ar_hs) begin
      arready_r <= 1'b0;
      rvalid_r  <= 1'b1;
    end else if (rvalid_r) begin
      if (axi_rready_i) rvalid_r <= 1'b0;
    end else begin
      arready_r <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      if (axi_araddr_i == `CFG_ADDR_STATUS) rdata_r <= {{(`CFG_AXI_DATA_BITS-1){1'b0}}, busy};
      else rdata_r <= '0; // nothing else is readable
    end
  end

  assign axi_awready_o = wr_ready_r;
  assign axi_wready_o  = wr_ready_r;
  assign axi_bvalid_o  = bvalid_r;
  assign axi_bresp_o   = 2'b00; // always OKAY
  assign axi_arready_o = arready_r;
  assign axi_rvalid_o  = rvalid_r;
  assign axi_rdata_o   = rdata_r;
  assign axi_rresp_o   = 2'b00;

endmodule

/* design/cfg_node.sv */
`timescale 1ns/10ps
`include "cfg_chain_defines.svh"

module cfg_node #(
  parameter logic [`CFG_ID_BITS-1:0]   NODE_ID      = `CFG_NODE0_ID,
  parameter logic [`CFG_DATA_BITS-1:0] DEFAULT_DATA = `CFG_NODE0_DEFAULT
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      line_i,
  output logic [`CFG_DATA_BITS-1:0] data_o,
  output logic                      new_o
);

  localparam int unsigned frame_stride = `CFG_FRAME_LEN + 1;

  cfg_chain_pkg::cfg_frame_u frame_r; // last 36 bits seen on the line
  cfg_chain_pkg::cfg_frame_u frame_n; // same window including the bit on the line now

  logic [`CFG_LEN_BITS-1:0]  count_r;  // hold-off after an accepted packet
  logic [`CFG_DATA_BITS-1:0] data_r;
  logic [`CFG_DATA_BITS-1:0] data_n;   // payload with the framing bits taken out
  logic                      new_r;
  logic                      reset_run;
  logic                      reset_start;
  logic                      pkt_valid;
  logic                      id_match;

  // new bits enter at the top, so bit 0 of the frame ends at position 0
  assign frame_n.raw = {line_i, frame_r.raw[`CFG_PKT_BITS-1:1]};

  // decode looks at frame_n so the update shows up right after the final bit
  assign reset_run   = &frame_n.raw;
  assign reset_start = reset_run & ~(&frame_r.raw); // only the first all ones cycle counts

  // while count_r runs the tail of the previous frame still fills the window
  assign pkt_valid = (frame_n.pkt.valid == `CFG_VALID_PATTERN) && (count_r == '0);
  assign id_match  = frame_n.pkt.id == NODE_ID;

  // drop every ninth rx bit, the rest pack down into the payload
  for (genvar i = 0; i < `CFG_RX_BITS; i++) begin : g_deframe
    if (((i + 1) % frame_stride) != 0) begin : g_payload
      assign data_n[i - i / frame_stride] = frame_n.pkt.rx[i];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      frame_r.raw <= '0;
      count_r     <= '0;
      data_r      <= DEFAULT_DATA;  // nodes come up holding their defaults
      new_r       <= 1'b0;
    end else begin
      frame_r <= frame_n;
      new_r   <= 1'b0;
      if (reset_start) begin
        data_r  <= DEFAULT_DATA;
        new_r   <= 1'b1;
        count_r <= '0;            // the ramp into a reset run can fake a header, forget it
      end else if (pkt_valid) begin
        count_r <= frame_n.pkt.len; // ignore the window for one frame length
        if (id_match) begin
          data_r <= data_n;
          new_r  <= 1'b1;
        end
      end else if (count_r != '0) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  assign data_o = data_r;
  assign new_o  = new_r; // one cycle per load or default restore

endmodule

/* design/cfg_serializer.sv */
`timescale 1ns/10ps
`include "cfg_chain_defines.svh"

module cfg_serializer (
  input  logic  clk,
  input  logic  reset,
  cfg_tx_if.ser tx
);

  localparam int unsigned frame_stride = `CFG_FRAME_LEN + 1; // payload bits plus their framing zero
  localparam logic [`CFG_LEN_BITS-1:0] pkt_len = `CFG_PKT_BITS;

  cfg_chain_pkg::cfg_packet_s pkt;
  logic [`CFG_PKT_BITS-1:0]   frame_word;
  logic [`CFG_PKT_BITS-1:0]   shift_r;    // bit 0 is what the line shows

  // pack the request into its line format
  always_comb begin
    pkt       = '0;                   // framing bits stay zero from here
    pkt.valid = `CFG_VALID_PATTERN;
    pkt.len   = pkt_len;
    pkt.id    = tx.id;
    for (int i = 0; i < `CFG_RX_BITS; i++) begin
      // every ninth position is a framing zero, the rest take the next payload bit
      if (((i + 1) % frame_stride) != 0) pkt.rx[i] = tx.data[i - i / frame_stride];
    end
  end

  // a reset run is all ones and therefore never looks like a packet
  assign frame_word = (tx.kind == cfg_chain_pkg::CFG_REQ_RESET) ? '1 : pkt;

  always_ff @(posedge clk) begin
    if (reset) begin
      shift_r <= '0;
    end else if (tx.start) begin
      shift_r <= frame_word;
    end else if (tx.last) begin
      shift_r <= '0;                    // make sure the line falls back to idle
    end else begin
      shift_r <= {1'b0, shift_r[`CFG_PKT_BITS-1:1]}; // zeros follow the frame out
    end
  end

  assign tx.line = shift_r[0]; // idle line stays low because the register drains to zero

endmodule

/* design/cfg_tx_if.sv */
`timescale 1ns/10ps
`include "cfg_chain_defines.svh"

// bundle shared by the sequencer, the serializer and the bit counter
interface cfg_tx_if;

  logic                       start; // one cycle launch, valid together with kind, id and data
  cfg_chain_pkg::cfg_req_e    kind;
  logic [`CFG_ID_BITS-1:0]    id;
  logic [`CFG_DATA_BITS-1:0]  data;
  logic                       last;  // bit counter is on the final bit of the frame
  logic                       line;  // serial bit as it leaves the serializer

  // the host launches and waits for the end of the frame
  modport host (output start, kind, id, data, input last);

  // the serializer builds the word on start and drops it after last
  modport ser (input start, kind, id, data, last, output line);

  // the counter only needs to know when a frame begins
  modport cnt (input start, output last);

endinterface

/* include/cfg_chain_defines.svh */
`ifndef CFG_CHAIN_DEFINES_SVH
`define CFG_CHAIN_DEFINES_SVH

// payload and framing geometry of one config packet
`define CFG_DATA_BITS      16
`define CFG_FRAME_LEN      8     // payload bits between two framing zeros
`define CFG_RX_BITS        18    // two frames of 8 payload bits plus one framing bit each
`define CFG_ID_BITS        8
`define CFG_LEN_BITS       8
`define CFG_VALID_BITS     2
`define CFG_VALID_PATTERN  2'b10 // low bit goes out first, so a packet always starts with a zero
`define CFG_PKT_BITS       36    // whole frame word and also the reset run length

// host side register map, AXI4-Lite word addresses
`define CFG_AXI_ADDR_BITS  4
`define CFG_AXI_DATA_BITS  32
`define CFG_ADDR_PACKET    4'h0  // id in wdata[23:16], data in wdata[15:0]
`define CFG_ADDR_RESET     4'h4  // any write starts a reset run
`define CFG_ADDR_STATUS    4'h8  // bit 0 is busy

// identity of the two nodes on the line
`define CFG_NODE0_ID       8'd1
`define CFG_NODE1_ID       8'd2
`define CFG_NODE0_DEFAULT  16'h1234
`define CFG_NODE1_DEFAULT  16'hA5A5

`endif

/* test/cfg_chain_properties.sv */
`timescale 1ns/10ps

module cfg_chain_properties (
  input logic clk,
  input logic reset,
  input logic axi_awready_i,
  input logic axi_bvalid_i,
  input logic axi_bready_i,
  input logic cfg_line_i,
  input logic busy_i       // host fsm is in its SEND state
);

  int unsigned assert_fails = 0; // read by the testbench at the end of the run

  // a write response stays up until the host takes it
  a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
    axi_bvalid_i && !axi_bready_i |=> axi_bvalid_i)
    else begin
      $error("bvalid dropped before bready");
      assert_fails++;
    end

  // nothing but idle zeros may show up outside a frame
  a_line_idle: assert property (@(posedge clk) disable iff (reset)
    !busy_i |-> !cfg_line_i)
    else begin
      $error("serial line high while the sequencer is not busy");
      assert_fails++;
    end

  a_no_write_during_resp: assert property (@(posedge clk) disable iff (reset)
    axi_bvalid_i |-> !axi_awready_i) // a new write waits for the old response
    else begin
      $error("awready high while bvalid is pending");
      assert_fails++;
    end

endmodule

bind cfg_chain_top cfg_chain_properties i_cfg_chain_properties (
  .clk           (clk),
  .reset         (reset),
  .axi_awready_i (axi_awready_o),
  .axi_bvalid_i  (axi_bvalid_o),
  .axi_bready_i  (axi_bready_i),
  .cfg_line_i    (cfg_line_o),
  .busy_i        (i_cfg_host_fsm.busy)
);

/* test/cfg_chain_tb.sv */
`timescale 1ns/10ps
`include "cfg_chain_defines.svh"

module cfg_chain_tb;

  localparam int num_requests = 60;
  localparam int cycle_limit  = num_requests * 80; // a request takes about 40 cycles

  logic        clk;
  logic        reset;
  logic        axi_awvalid, axi_awready, axi_wvalid, axi_wready;
  logic [3:0]  axi_awaddr, axi_araddr;
  logic [31:0] axi_wdata, axi_rdata;
  logic        axi_bvalid, axi_bready, axi_arvalid, axi_arready, axi_rvalid, axi_rready;
  logic [1:0]  axi_bresp, axi_rresp;
  logic [15:0] node0_data, node1_data;
  logic        node0_new, node1_new, cfg_line;

  logic [31:0] lfsr_r = 32'd81413;
  int unsigned cycle_cnt = 0;
  int unsigned error_cnt = 0;
  int unsigned new_seen [2] = '{0, 0};     // pulses counted on the new outputs
  int unsigned new_expected [2] = '{0, 0}; // pulses the model predicts
  logic [15:0] data_expected [2];

  cfg_chain_top i_cfg_chain_top (
    .clk (clk), .reset (reset),
    .axi_awvalid_i (axi_awvalid), .axi_awready_o (axi_awready), .axi_awaddr_i (axi_awaddr),
    .axi_wvalid_i (axi_wvalid), .axi_wready_o (axi_wready), .axi_wdata_i (axi_wdata),
    .axi_bvalid_o (axi_bvalid), .axi_bready_i (axi_bready), .axi_bresp_o (axi_bresp),
    .axi_arvalid_i (axi_arvalid), .axi_arready_o (axi_arready), .axi_araddr_i (axi_araddr),
    .axi_rvalid_o (axi_rvalid), .axi_rready_i (axi_rready), .axi_rdata_o (axi_rdata),
    .axi_rresp_o (axi_rresp),
    .node0_data_o (node0_data), .node1_data_o (node1_data),
    .node0_new_o (node0_new), .node1_new_o (node1_new), .cfg_line_o (cfg_line)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, the request sequence never finished", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // outputs only move on the rising edge, so the falling edge sees them settled
  always @(negedge clk) begin
    if (!reset) begin
      if (node0_new) new_seen[0]++;
      if (node1_new) new_seen[1]++;
    end
  end

  // fibonacci lfsr with taps 32 22 2 1 that steps once per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
      lfsr_r = {lfsr_r[30:0], fb};
      value  = {value[30:0], fb};
    end
    return value;
  endfunction

  // frame as it should appear on the line with bit 0 sent first
  function automatic logic [35:0] expected_frame(input logic is_reset, input logic [7:0] id,
                                                 input logic [15:0] data);
    if (is_reset) return '1; // reset run is all ones
    // two payload bytes each closed by a framing zero sit above id, len and the 2'b10 marker
    return {1'b0, data[15:8], 1'b0, data[7:0], id, 8'(`CFG_PKT_BITS), 2'b10};
  endfunction

  task automatic report_mismatch(input string name, input logic [35:0] expected,
                                 input logic [35:0] actual);
    error_cnt++;
    $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
  endtask

  // called on a falling edge and returns on a falling edge
  task automatic read_status(output logic [31:0] value);
    axi_araddr  = `CFG_ADDR_STATUS;
    axi_arvalid = 1'b1;
    while (!axi_arready) @(negedge clk);
    @(negedge clk);                      // address was taken on the rising edge just passed
    axi_arvalid = 1'b0;
    while (!axi_rvalid) @(negedge clk);
    value = axi_rdata;
    if (axi_rresp !== 2'b00) report_mismatch("status rresp", 0, axi_rresp);
    axi_rready = 1'b1;
    @(negedge clk);
    axi_rready = 1'b0;
  endtask

  task automatic check_nodes(input string tag);
    if (node0_data !== data_expected[0])
      report_mismatch({tag, " node0 data"}, data_expected[0], node0_data);
    if (node1_data !== data_expected[1])
      report_mismatch({tag, " node1 data"}, data_expected[1], node1_data);
    if (new_seen[0] != new_expected[0])
      report_mismatch({tag, " node0 new pulses"}, new_expected[0], new_seen[0]);
    if (new_seen[1] != new_expected[1])
      report_mismatch({tag, " node1 new pulses"}, new_expected[1], new_seen[1]);
  endtask

  task automatic send_request(input int idx, input logic is_reset, input logic [7:0] id,
                              input logic [15:0] data);
    logic [35:0] line_bits;
    logic [31:0] status;
    string       tag;
    tag         = $sformatf("request %0d", idx);
    axi_awaddr  = is_reset ? `CFG_ADDR_RESET : `CFG_ADDR_PACKET;
    axi_wdata   = {8'h00, id, data};
    axi_awvalid = 1'b1;
    axi_wvalid  = 1'b1;
    while (!(axi_awready && axi_wready)) @(negedge clk); // host opens up after the last response
    @(negedge clk);                                       // bit 0 is on the line from here
    axi_awvalid = 1'b0;
    axi_wvalid  = 1'b0;
    fork
      begin
        for (int k = 0; k < `CFG_PKT_BITS; k++) begin
          if (k > 0) @(negedge clk);
          line_bits[k] = cfg_line;
        end
      end
      read_status(status); // polled while the frame is going out
    join
    if (status[0] !== 1'b1) report_mismatch({tag, " busy during frame"}, 1, status[0]);
    if (line_bits !== expected_frame(is_reset, id, data))
      report_mismatch({tag, " line frame"}, expected_frame(is_reset, id, data), line_bits);
    axi_bready = 1'b1;
    while (!axi_bvalid) @(negedge clk);
    if (axi_bresp !== 2'b00) report_mismatch({tag, " bresp"}, 0, axi_bresp);
    @(negedge clk); // nodes pulse in this cycle
    axi_bready = 1'b0;
    @(negedge clk);
    if (is_reset) begin
      data_expected[0] = `CFG_NODE0_DEFAULT;
      data_expected[1] = `CFG_NODE1_DEFAULT;
      new_expected[0]++;
      new_expected[1]++;
    end else if (id == `CFG_NODE0_ID) begin
      data_expected[0] = data;
      new_expected[0]++;
    end else if (id == `CFG_NODE1_ID) begin
      data_expected[1] = data;
      new_expected[1]++;
    end // ids 0 and 3 reach nobody
    check_nodes(tag);
  endtask

  initial begin
    logic        is_reset;
    logic [7:0]  id;
    logic [15:0] data;
    logic [31:0] status;
    reset       = 1'b1;
    axi_awvalid = 1'b0;
    axi_awaddr  = '0;
    axi_wvalid  = 1'b0;
    axi_wdata   = '0;
    axi_bready  = 1'b0;
    axi_arvalid = 1'b0;
    axi_araddr  = '0;
    axi_rready  = 1'b0;
    data_expected[0] = `CFG_NODE0_DEFAULT;
    data_expected[1] = `CFG_NODE1_DEFAULT;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_nodes("after reset");
    if (node0_new !== 1'b0) report_mismatch("after reset node0 new", 0, node0_new);
    if (node1_new !== 1'b0) report_mismatch("after reset node1 new", 0, node1_new);
    for (int n = 0; n < num_requests; n++) begin
      is_reset = rand_bits(2) == 0; // about one request in four is a reset run
      id       = 8'(rand_bits(2));
      data     = 16'(rand_bits(16));
      send_request(n, is_reset, id, data);
    end
    read_status(status);
    if (status[0] !== 1'b0) report_mismatch("idle status busy", 0, status[0]);
    error_cnt += i_cfg_chain_top.i_cfg_chain_properties.assert_fails;
    $display("requests: %0d, errors: %0d, assertion failures: %0d", num_requests, error_cnt,
             i_cfg_chain_top.i_cfg_chain_properties.assert_fails);
    if (error_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
